// File: cache_memory/cache_memory.sv
////////////////////////////////////////////////////////////////////////////
// Data cache memory core
// per-way tag/data RAMs, valid/dirty flops, fill bypass, registered results
////////////////////////////////////////////////////////////////////////////

module cache_memory (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                stall_i,
  input  logic                                flushing_i,
  input  logic                                filling_i,
  input  logic                                rreq_i,       // read wins over wb write
  input  logic [cache_pkg::WAYS-1:0]          fill_way_i,   // one-hot victim
  input  cache_pkg::lookup_t                  lookup_i,
  input  cache_pkg::fill_addr_t               fill_addr_i,
  input  cache_pkg::wb_req_t                  wb_i,
  input  cache_pkg::line_u                    biu_line_i,
  input  logic                                biu_line_dirty_i,
  input  logic                                biucmd_ack_i,
  output cache_pkg::mem_rsp_t                 rsp_o,
  output cache_pkg::evict_t                   evict_o
);

  ////////////////////////////////////////////////////////////////////////////
  // write side
  ////////////////////////////////////////////////////////////////////////////

  logic                                               fill_we;      // BIU line write
  logic                                               wb_we;        // write buffer write
  logic                                               we_dly;       // masks next compare
  logic [cache_pkg::IDX_BITS-1:0]                     idx;          // RAM address
  logic [cache_pkg::IDX_BITS-1:0]                     idx_filling;  // frozen fill index
  logic [cache_pkg::IDX_BITS-1:0]                     rd_idx_dly;   // lookup idx, RAM aligned
  logic [cache_pkg::WAYS-1:0]                         fill_way_dly; // frozen fill way
  logic [cache_pkg::WAYS-1:0]                         way_fill_we;
  logic [cache_pkg::WAYS-1:0]                         way_wb_we;
  logic [cache_pkg::WAYS-1:0]                         dat_we;
  logic [cache_pkg::WAYS-1:0][cache_pkg::SETS-1:0]    valid_q;
  logic [cache_pkg::WAYS-1:0][cache_pkg::SETS-1:0]    dirty_q;
  cache_pkg::tag_entry_t                              tag_in;
  cache_pkg::line_u                                   wb_line;      // wb word in its slot
  cache_pkg::line_u                                   dat_in;
  logic [cache_pkg::BLK_BITS/8-1:0]                   dat_be;

  assign fill_we = filling_i & biucmd_ack_i;
  assign wb_we   = wb_i.we & ~rreq_i & ~fill_we;  // fill owns the RAMs this cycle

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      we_dly       <= 1'b0;
      fill_way_dly <= {{(cache_pkg::WAYS-1){1'b0}}, 1'b1};  // way 0, as victim ptr
    end
    else
    begin
      we_dly <= fill_we | wb_we;
      if (!filling_i) fill_way_dly <= fill_way_i;  // hold for whole fill
    end
  end

  always_ff @(posedge clk_i)
  begin
    rd_idx_dly <= lookup_i.idx;
    if (!filling_i) idx_filling <= fill_addr_i.idx;
  end

  // RAM index, fill > write buffer > lookup
  always_comb
  begin
    if (fill_we)    idx = idx_filling;
    else if (wb_we) idx = wb_i.idx;
    else            idx = lookup_i.idx;
  end

  // place wb word into its slot of the line
  always_comb
  begin
    wb_line                = '0;
    wb_line.word[wb_i.offs] = wb_i.data;
  end

  assign dat_in = fill_we ? biu_line_i : wb_line;
  assign dat_be = fill_we ? {(cache_pkg::BLK_BITS/8){1'b1}}
                          : {{((cache_pkg::BLK_BITS-cache_pkg::XLEN)/8){1'b0}}, wb_i.be}
                            << (wb_i.offs * (cache_pkg::XLEN/8));

  assign way_fill_we = {cache_pkg::WAYS{fill_we}} & fill_way_dly;
  assign way_wb_we   = {cache_pkg::WAYS{wb_we}} & wb_i.ways_hit;
  assign dat_we      = way_fill_we | way_wb_we;

  // tag word written on fill
  assign tag_in = '{valid: 1'b1, dirty: biu_line_dirty_i, tag: fill_addr_i.tag};

  // valid and dirty flops
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      valid_q <= '0;
      dirty_q <= '0;
    end
    else
    begin
      for (int w = 0; w < cache_pkg::WAYS; w++)
      begin
        if (flushing_i)         valid_q[w]      <= '0;  // flush clears all sets
        else if (way_fill_we[w]) valid_q[w][idx] <= tag_in.valid;
        if (way_fill_we[w])     dirty_q[w][idx] <= tag_in.dirty;
        else if (way_wb_we[w])  dirty_q[w][idx] <= 1'b1;  // cpu store dirties line
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // fill bypass
  ////////////////////////////////////////////////////////////////////////////

  logic                              byp_valid;
  logic                              use_byp;
  logic [cache_pkg::IDX_BITS-1:0]    byp_idx;
  logic [cache_pkg::TAG_BITS-1:0]    byp_tag;
  logic [cache_pkg::WAYS-1:0]        byp_way;
  cache_pkg::line_u                  byp_line;

  always_ff @(posedge clk_i)
  begin
    if (fill_we)
    begin
      byp_idx  <= idx_filling;
      byp_tag  <= fill_addr_i.tag;
      byp_way  <= fill_way_dly;
      byp_line <= biu_line_i;
    end
  end

  // a later wb write to the same set makes the copy stale
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)                              byp_valid <= 1'b0;
    else if (flushing_i)                      byp_valid <= 1'b0;
    else if (fill_we)                         byp_valid <= 1'b1;
    else if (wb_we && (wb_i.idx == byp_idx))  byp_valid <= 1'b0;
  end

  assign use_byp = byp_valid & (rd_idx_dly == byp_idx);

  ////////////////////////////////////////////////////////////////////////////
  // per-way RAMs and compare
  ////////////////////////////////////////////////////////////////////////////

  logic [cache_pkg::TAG_BITS-1:0]    ram_tag  [cache_pkg::WAYS];
  cache_pkg::line_u                  ram_line [cache_pkg::WAYS];
  cache_pkg::tag_entry_t             tag_out  [cache_pkg::WAYS];
  cache_pkg::line_u                  dat_out  [cache_pkg::WAYS];
  logic [cache_pkg::WAYS-1:0]        way_hit;
  logic [cache_pkg::WAYS-1:0]        way_dirty;

  for (genvar w = 0; w < cache_pkg::WAYS; w++)
  begin : gen_way
    ram_1rw #(
      .ABITS  (cache_pkg::IDX_BITS),
      .DBITS  (cache_pkg::TAG_BITS)
    ) u_tag_ram (
      .clk_i  (clk_i),
      .rst_ni (rst_ni),
      .addr_i (idx),
      .we_i   (way_fill_we[w]),
      .be_i   ({((cache_pkg::TAG_BITS+7)/8){1'b1}}),
      .din_i  (tag_in.tag),
      .dout_o (ram_tag[w])
    );

    ram_1rw #(
      .ABITS  (cache_pkg::IDX_BITS),
      .DBITS  (cache_pkg::BLK_BITS)
    ) u_dat_ram (
      .clk_i  (clk_i),
      .rst_ni (rst_ni),
      .addr_i (idx),
      .we_i   (dat_we[w]),
      .be_i   (dat_be),
      .din_i  (dat_in),
      .dout_o (ram_line[w])
    );

    // bypass replaces only the way last filled
    assign tag_out[w] = '{valid: valid_q[w][rd_idx_dly],
                          dirty: dirty_q[w][rd_idx_dly],
                          tag:   (use_byp && byp_way[w]) ? byp_tag : ram_tag[w]};
    assign dat_out[w] = (use_byp && byp_way[w]) ? byp_line : ram_line[w];

    assign way_hit[w]   = tag_out[w].valid & (tag_out[w].tag == lookup_i.tag);
    assign way_dirty[w] = tag_out[w].valid & tag_out[w].dirty;
  end

  ////////////////////////////////////////////////////////////////////////////
  // result muxes and registers
  ////////////////////////////////////////////////////////////////////////////

  cache_pkg::line_u                  hit_line;
  cache_pkg::line_u                  vic_line;
  logic [cache_pkg::TAG_BITS-1:0]    vic_tag;
  logic [cache_pkg::WAYS-1:0]        ways_hit_d;

  assign ways_hit_d = way_hit & {cache_pkg::WAYS{~we_dly}};  // RAM read was displaced

  // AND-OR muxes, hit way and victim way
  always_comb
  begin
    hit_line = '0;
    vic_line = '0;
    vic_tag  = '0;
    for (int w = 0; w < cache_pkg::WAYS; w++)
    begin
      hit_line.blk |= dat_out[w].blk & {cache_pkg::BLK_BITS{way_hit[w]}};
      vic_line.blk |= dat_out[w].blk & {cache_pkg::BLK_BITS{fill_way_dly[w]}};
      vic_tag      |= tag_out[w].tag & {cache_pkg::TAG_BITS{fill_way_dly[w]}};
    end
  end

  logic                          hit_q;
  logic [cache_pkg::WAYS-1:0]    ways_hit_q;
  logic                          dirty_q_o;
  logic [cache_pkg::WAYS-1:0]    ways_dirty_q;
  logic                          way_dirty_q;
  cache_pkg::line_u              line_q;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      hit_q        <= 1'b0;
      ways_hit_q   <= '0;
      dirty_q_o    <= 1'b0;
      ways_dirty_q <= '0;
      way_dirty_q  <= 1'b0;
    end
    else if (!stall_i)  // hold during stall
    begin
      hit_q        <= |ways_hit_d;
      ways_hit_q   <= ways_hit_d;
      dirty_q_o    <= |way_dirty;
      ways_dirty_q <= way_dirty;
      way_dirty_q  <= |(way_dirty & fill_way_dly);
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (!stall_i)
    begin
      line_q       <= hit_line;
      evict_o.tag  <= vic_tag;
      evict_o.line <= vic_line;
    end
  end

  assign rsp_o = '{hit:        hit_q,
                   ways_hit:   ways_hit_q,
                   dirty:      dirty_q_o,
                   ways_dirty: ways_dirty_q,
                   way_dirty:  way_dirty_q,
                   line:       line_q};

endmodule

// File: cache_memory/fill_way_select.sv
////////////////////////////////////////////////////////////////////////////
// Fill victim selector
// round-robin one-hot way pointer, steps once per completed fill
////////////////////////////////////////////////////////////////////////////

module fill_way_select (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       filling_i,     // fill in progress
  input  logic                       biucmd_ack_i,  // BIU beat accepted
  output logic [cache_pkg::WAYS-1:0] fill_way_o     // one-hot victim
);

  logic [cache_pkg::WAYS-1:0] way_ptr;
  logic                       acked;  // fill saw at least one ack

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      way_ptr <= {{(cache_pkg::WAYS-1){1'b0}}, 1'b1};  // start at way 0
      acked   <= 1'b0;
    end
    else if (filling_i)
    begin
      if (biucmd_ack_i) acked <= 1'b1;
    end
    else if (acked)
    begin
      // fill finished, rotate left by one way
      way_ptr <= {way_ptr[cache_pkg::WAYS-2:0], way_ptr[cache_pkg::WAYS-1]};
      acked   <= 1'b0;
    end
  end

  assign fill_way_o = way_ptr;

endmodule

// File: common/cache_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Data cache storage package
// cache geometry, tag word, lookup/fill/write-buffer requests and results
////////////////////////////////////////////////////////////////////////////

package cache_pkg;

  // geometry
  localparam int XLEN          = 32;   // data word
  localparam int BLK_BITS      = 128;  // one cache line
  localparam int WAYS          = 2;
  localparam int SETS          = 16;
  localparam int IDX_BITS      = 4;    // log2(SETS)
  localparam int BLK_OFFS_BITS = 4;    // byte offset in line
  localparam int DAT_OFFS_BITS = 2;    // word offset in line
  localparam int TAG_BITS      = XLEN - IDX_BITS - BLK_OFFS_BITS;

  // tag memory word of one way
  // valid and dirty live in flops, only tag goes to RAM
  typedef struct packed {
    logic                valid;
    logic                dirty;
    logic [TAG_BITS-1:0] tag;
  } tag_entry_t;

  // one cache line, seen as raw block or as words
  typedef union packed {
    logic [BLK_BITS-1:0]                 blk;
    logic [BLK_BITS/XLEN-1:0][XLEN-1:0]  word;  // word[offs]
  } line_u;

  // core lookup address
  typedef struct packed {
    logic [TAG_BITS-1:0] tag;  // needed one cycle after idx
    logic [IDX_BITS-1:0] idx;
  } lookup_t;

  // address of line being filled
  typedef struct packed {
    logic [TAG_BITS-1:0] tag;
    logic [IDX_BITS-1:0] idx;
  } fill_addr_t;

  // write buffer request
  typedef struct packed {
    logic                     we;        // write strobe
    logic [XLEN/8-1:0]        be;        // byte enables within word
    logic [IDX_BITS-1:0]      idx;
    logic [DAT_OFFS_BITS-1:0] offs;      // word slot
    logic [XLEN-1:0]          data;
    logic [WAYS-1:0]          ways_hit;  // target way(s)
  } wb_req_t;

  // lookup result
  typedef struct packed {
    logic            hit;
    logic [WAYS-1:0] ways_hit;
    logic            dirty;       // any way dirty
    logic [WAYS-1:0] ways_dirty;
    logic            way_dirty;   // victim way dirty
    line_u           line;
  } mem_rsp_t;

  // victim line for write-back
  typedef struct packed {
    logic [TAG_BITS-1:0] tag;
    line_u               line;
  } evict_t;

endpackage

// File: dv/cache_mem_assert.sv
////////////////////////////////////////////////////////////////////////////
// Cache memory assertions
// write-port exclusion, stall hold, reset state of hit
////////////////////////////////////////////////////////////////////////////

module cache_mem_assert (
  input logic                       clk_i,
  input logic                       rst_ni,
  input logic                       stall_i,
  input logic                       rreq_i,
  input logic [cache_pkg::WAYS-1:0] way_fill_we,
  input cache_pkg::wb_req_t         wb_i,
  input cache_pkg::mem_rsp_t        rsp_o
);

  // a store request never names the way being filled
  a_one_writer: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(|(way_fill_we & wb_i.ways_hit & {cache_pkg::WAYS{wb_i.we & ~rreq_i}})))
    else $error("fill and write buffer target the same way");

  // stalled results keep their value
  a_stall_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    stall_i |=> $stable(rsp_o))
    else $error("rsp_o changed during stall");

  a_reset_hit: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> !rsp_o.hit)  // reset value seen at release
    else $error("hit high after reset");

endmodule

// File: dv/cache_mem_tb.sv
////////////////////////////////////////////////////////////////////////////
// Data cache storage testbench
// table-driven fills, stores, lookups, flush and stall against a model
////////////////////////////////////////////////////////////////////////////

module cache_mem_tb;

  typedef enum logic [2:0] {OP_LOOKUP, OP_FILL, OP_WB, OP_FLUSH, OP_STALL} op_e;

  // one table row with its expected hit
  typedef struct packed {
    op_e                                 op;
    logic [cache_pkg::IDX_BITS-1:0]      idx;
    logic [cache_pkg::TAG_BITS-1:0]      tag;
    logic                                dirty;    // fill dirty flag
    logic [cache_pkg::XLEN/8-1:0]        be;       // store byte enables
    logic [cache_pkg::DAT_OFFS_BITS-1:0] offs;     // store word slot
    logic                                exp_hit;
  } row_t;

  logic                  clk_i;
  logic                  rst_ni;
  logic                  stall_i;
  logic                  flushing_i;
  logic                  filling_i;
  logic                  rreq_i;
  cache_pkg::lookup_t    lookup_i;
  cache_pkg::fill_addr_t fill_addr_i;
  cache_pkg::wb_req_t    wb_i;
  cache_pkg::line_u      biu_line_i;
  logic                  biu_line_dirty_i;
  logic                  biucmd_ack_i;
  cache_pkg::mem_rsp_t   rsp_o;
  cache_pkg::evict_t     evict_o;

  row_t rows[$];
  int   seed = 5625;
  int   cycles = 0;
  int   limit = 1000;

  // reference model state
  logic [cache_pkg::TAG_BITS-1:0] m_tag     [cache_pkg::WAYS][cache_pkg::SETS];
  cache_pkg::line_u               m_line    [cache_pkg::WAYS][cache_pkg::SETS];
  bit                             m_valid   [cache_pkg::WAYS][cache_pkg::SETS];
  bit                             m_dirty   [cache_pkg::WAYS][cache_pkg::SETS];
  bit                             m_written [cache_pkg::WAYS][cache_pkg::SETS];
  int                             m_ptr = 0;  // victim way

  cache_mem_top dut_i (.*);

  bind cache_memory cache_mem_assert u_cache_mem_assert (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .stall_i     (stall_i),
    .rreq_i      (rreq_i),
    .way_fill_we (way_fill_we),
    .wb_i        (wb_i),
    .rsp_o       (rsp_o)
  );

  always #50 clk_i = ~clk_i;  // period 100

  // run limit from table length
  always @(posedge clk_i)
  begin
    cycles++;
    if (cycles > limit)
    begin
      $display("Timeout: the table did not finish within %0d cycles", limit);
      fail_stop("timeout");
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // reporting and compare
  ////////////////////////////////////////////////////////////////////////////

  task automatic fail_stop(input string why);
    $display("Done: errors found");
    $fatal(1, why);
  endtask

  task automatic check_rsp(input cache_pkg::mem_rsp_t act, input cache_pkg::mem_rsp_t exp,
                           input int row);
    if (act !== exp)
    begin
      $display("ERROR %0t: rsp row %0d got %h exp %h", $time, row, act, exp);
      fail_stop("rsp mismatch");
    end
  endtask

  task automatic check_evict(input cache_pkg::evict_t act, input cache_pkg::evict_t exp,
                             input int row);
    if (act !== exp)
    begin
      $display("ERROR %0t: evict row %0d got %h exp %h", $time, row, act, exp);
      fail_stop("evict mismatch");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // model lookups
  ////////////////////////////////////////////////////////////////////////////

  function automatic cache_pkg::mem_rsp_t predict_rsp(
    input logic [cache_pkg::IDX_BITS-1:0] s,
    input logic [cache_pkg::TAG_BITS-1:0] t
  );
    cache_pkg::mem_rsp_t r;
    r = '0;  // miss gives zero line
    for (int w = 0; w < cache_pkg::WAYS; w++)
    begin
      if (m_valid[w][s] && m_tag[w][s] == t)
      begin
        r.ways_hit[w] = 1'b1;
        r.line        = m_line[w][s];
      end
      r.ways_dirty[w] = m_valid[w][s] & m_dirty[w][s];
    end
    r.hit       = |r.ways_hit;
    r.dirty     = |r.ways_dirty;
    r.way_dirty = r.ways_dirty[m_ptr];  // victim way only
    return r;
  endfunction

  function automatic cache_pkg::evict_t victim_entry(input logic [cache_pkg::IDX_BITS-1:0] s);
    cache_pkg::evict_t e;
    e.tag  = m_tag[m_ptr][s];
    e.line = m_line[m_ptr][s];
    return e;
  endfunction

  function automatic cache_pkg::line_u rand_line();
    cache_pkg::line_u l;
    for (int k = 0; k < cache_pkg::BLK_BITS / cache_pkg::XLEN; k++)
      l.word[k] = $random(seed);
    return l;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // bus drivers
  ////////////////////////////////////////////////////////////////////////////

  // idx in cycle N then tag in N+1 and result after the next edge
  task automatic lookup_set(input logic [cache_pkg::IDX_BITS-1:0] s,
                            input logic [cache_pkg::TAG_BITS-1:0] t, input bit stl);
    @(posedge clk_i);
    lookup_i.idx <= s;
    stall_i      <= stl;
    @(posedge clk_i);
    lookup_i.tag <= t;
    @(posedge clk_i);
    stall_i <= 1'b0;          // flops already saw stall
    @(negedge clk_i);         // settled outputs
  endtask

  task automatic fill_set(input logic [cache_pkg::IDX_BITS-1:0] s,
                          input logic [cache_pkg::TAG_BITS-1:0] t, input logic d,
                          input cache_pkg::line_u l);
    @(posedge clk_i);
    fill_addr_i <= '{tag: t, idx: s};  // index frozen before filling
    @(posedge clk_i);
    filling_i        <= 1'b1;
    biucmd_ack_i     <= 1'b1;
    biu_line_i       <= l;
    biu_line_dirty_i <= d;
    @(posedge clk_i);
    filling_i    <= 1'b0;
    biucmd_ack_i <= 1'b0;
    repeat (2) @(posedge clk_i);  // pointer rotates and victim settles
  endtask

  task automatic store_word(input logic [cache_pkg::IDX_BITS-1:0] s,
                            input logic [cache_pkg::DAT_OFFS_BITS-1:0] offs,
                            input logic [cache_pkg::XLEN/8-1:0] be,
                            input logic [cache_pkg::XLEN-1:0] d,
                            input logic [cache_pkg::WAYS-1:0] ways);
    @(posedge clk_i);
    wb_i <= '{we: 1'b1, be: be, idx: s, offs: offs, data: d, ways_hit: ways};
    @(posedge clk_i);
    wb_i.we <= 1'b0;
    @(posedge clk_i);
  endtask

  task automatic add_row(input op_e op, input logic [cache_pkg::IDX_BITS-1:0] s,
                         input logic [cache_pkg::TAG_BITS-1:0] t, input logic d,
                         input logic [cache_pkg::XLEN/8-1:0] be,
                         input logic [cache_pkg::DAT_OFFS_BITS-1:0] offs, input logic h);
    rows.push_back('{op: op, idx: s, tag: t, dirty: d, be: be, offs: offs, exp_hit: h});
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    cache_pkg::mem_rsp_t        exp_r;
    cache_pkg::mem_rsp_t        last_r;
    cache_pkg::evict_t          exp_e;
    cache_pkg::evict_t          last_e;
    cache_pkg::line_u           l;
    bit                         last_e_chk;
    logic [cache_pkg::WAYS-1:0] ways;
    logic [cache_pkg::XLEN-1:0] d;
    clk_i            = 0;
    rst_ni           = 0;
    stall_i          = 0;
    flushing_i       = 0;
    filling_i        = 0;
    rreq_i           = 0;
    lookup_i         = '0;
    fill_addr_i      = '0;
    wb_i             = '0;
    biu_line_i       = '0;
    biu_line_dirty_i = 0;
    biucmd_ack_i     = 0;
    last_r           = '0;
    last_e           = '0;
    last_e_chk       = 0;
    foreach (m_valid[w, s])
    begin
      m_valid[w][s]   = 0;
      m_dirty[w][s]   = 0;
      m_written[w][s] = 0;
    end
    add_row(OP_LOOKUP, 3, 'h11, 0, 0, 0, 0);   // cold miss
    add_row(OP_FILL,   3, 'hAA, 0, 0, 0, 0);   // way 0
    add_row(OP_LOOKUP, 3, 'hAA, 0, 0, 0, 1);   // via bypass
    add_row(OP_FILL,   7, 'hCC, 1, 0, 0, 0);   // way 1 dirty
    add_row(OP_LOOKUP, 3, 'hAA, 0, 0, 0, 1);   // from RAM
    add_row(OP_LOOKUP, 7, 'hCC, 0, 0, 0, 1);
    add_row(OP_LOOKUP, 3, 'h55, 0, 0, 0, 0);   // other tag
    add_row(OP_WB,     3, 'hAA, 0, 4'b0101, 2, 0);
    add_row(OP_LOOKUP, 3, 'hAA, 0, 0, 0, 1);   // merged bytes and dirty
    add_row(OP_FILL,   9, 'hEE, 0, 0, 0, 0);   // way 0
    add_row(OP_FILL,   3, 'hBB, 1, 0, 0, 0);   // way 1 fills set 3
    add_row(OP_LOOKUP, 3, 'hBB, 0, 0, 0, 1);   // evict names way 0
    add_row(OP_LOOKUP, 3, 'hAA, 0, 0, 0, 1);
    add_row(OP_STALL,  7, 'hCC, 0, 0, 0, 1);   // outputs hold
    add_row(OP_LOOKUP, 7, 'hCC, 0, 0, 0, 1);
    add_row(OP_FLUSH,  0, 0,    0, 0, 0, 0);
    add_row(OP_LOOKUP, 3, 'hAA, 0, 0, 0, 0);
    add_row(OP_LOOKUP, 7, 'hCC, 0, 0, 0, 0);
    add_row(OP_FILL,   7, 'hCC, 0, 0, 0, 0);   // refill after flush
    add_row(OP_LOOKUP, 7, 'hCC, 0, 0, 0, 1);
    limit = rows.size() * 6 + 8 + 4;
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;
    foreach (rows[i])
    begin
      case (rows[i].op)
        OP_FILL:
        begin
          l = rand_line();
          fill_set(rows[i].idx, rows[i].tag, rows[i].dirty, l);
          m_tag[m_ptr][rows[i].idx]     = rows[i].tag;
          m_line[m_ptr][rows[i].idx]    = l;
          m_valid[m_ptr][rows[i].idx]   = 1;
          m_dirty[m_ptr][rows[i].idx]   = rows[i].dirty;
          m_written[m_ptr][rows[i].idx] = 1;
          m_ptr = (m_ptr + 1) % cache_pkg::WAYS;  // next victim
        end
        OP_WB:
        begin
          d     = $random(seed);
          exp_r = predict_rsp(rows[i].idx, rows[i].tag);
          ways  = exp_r.ways_hit;
          store_word(rows[i].idx, rows[i].offs, rows[i].be, d, ways);
          for (int w = 0; w < cache_pkg::WAYS; w++)
          begin
            if (ways[w])
            begin
              for (int b = 0; b < cache_pkg::XLEN / 8; b++)
                if (rows[i].be[b])
                  m_line[w][rows[i].idx].word[rows[i].offs][8*b +: 8] = d[8*b +: 8];
              m_dirty[w][rows[i].idx] = 1;
            end
          end
        end
        OP_FLUSH:
        begin
          @(posedge clk_i);
          flushing_i <= 1'b1;
          @(posedge clk_i);
          flushing_i <= 1'b0;
          foreach (m_valid[w, s])
            m_valid[w][s] = 0;
        end
        OP_STALL:
        begin
          lookup_set(rows[i].idx, rows[i].tag, 1'b1);
          check_rsp(rsp_o, last_r, i);   // previous result held
          if (last_e_chk)
            check_evict(evict_o, last_e, i);
        end
        default:
        begin
          exp_r = predict_rsp(rows[i].idx, rows[i].tag);
          exp_e = victim_entry(rows[i].idx);
          if (exp_r.hit !== rows[i].exp_hit)
            fail_stop($sformatf("table row %0d and model disagree on hit", i));
          lookup_set(rows[i].idx, rows[i].tag, 1'b0);
          check_rsp(rsp_o, exp_r, i);
          last_r     = exp_r;
          last_e_chk = m_written[m_ptr][rows[i].idx];  // victim RAM word known
          last_e     = exp_e;
          if (last_e_chk)
            check_evict(evict_o, exp_e, i);
        end
      endcase
    end
    $display("Done: no errors");
    $finish;
  end

endmodule

// File: sim.f
common/cache_pkg.sv
source/ram_1rw.sv
cache_memory/fill_way_select.sv
cache_memory/cache_memory.sv
source/cache_mem_top.sv
dv/cache_mem_assert.sv
dv/cache_mem_tb.sv

// File: source/cache_mem_top.sv
////////////////////////////////////////////////////////////////////////////
// Data cache storage top
// victim selector next to tag/data memory core
////////////////////////////////////////////////////////////////////////////

module cache_mem_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  stall_i,
  input  logic                  flushing_i,
  input  logic                  filling_i,
  input  logic                  rreq_i,
  input  cache_pkg::lookup_t    lookup_i,
  input  cache_pkg::fill_addr_t fill_addr_i,
  input  cache_pkg::wb_req_t    wb_i,
  input  cache_pkg::line_u      biu_line_i,
  input  logic                  biu_line_dirty_i,
  input  logic                  biucmd_ack_i,
  output cache_pkg::mem_rsp_t   rsp_o,
  output cache_pkg::evict_t     evict_o
);

  logic [cache_pkg::WAYS-1:0] fill_way;  // current victim

  fill_way_select u_fill_way_select (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .filling_i    (filling_i),
    .biucmd_ack_i (biucmd_ack_i),
    .fill_way_o   (fill_way)
  );

  cache_memory u_cache_memory (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .stall_i          (stall_i),
    .flushing_i       (flushing_i),
    .filling_i        (filling_i),
    .rreq_i           (rreq_i),
    .fill_way_i       (fill_way),
    .lookup_i         (lookup_i),
    .fill_addr_i      (fill_addr_i),
    .wb_i             (wb_i),
    .biu_line_i       (biu_line_i),
    .biu_line_dirty_i (biu_line_dirty_i),
    .biucmd_ack_i     (biucmd_ack_i),
    .rsp_o            (rsp_o),
    .evict_o          (evict_o)
  );

endmodule

// File: source/ram_1rw.sv
////////////////////////////////////////////////////////////////////////////
// Generic single-port synchronous RAM
// registered read port, byte-enabled writes
////////////////////////////////////////////////////////////////////////////

module ram_1rw #(
  parameter int ABITS = 4,
  parameter int DBITS = 32
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic [ABITS-1:0]       addr_i,
  input  logic                   we_i,
  input  logic [(DBITS+7)/8-1:0] be_i,    // one bit per byte lane
  input  logic [DBITS-1:0]       din_i,
  output logic [DBITS-1:0]       dout_o
);

  logic [DBITS-1:0] mem [2**ABITS];  // storage array

  // write port, only enabled lanes change
  always_ff @(posedge clk_i)
  begin
    if (we_i)
    begin
      for (int i = 0; i < DBITS; i++)
      begin
        if (be_i[i/8]) mem[addr_i][i] <= din_i[i];  // lane of bit i
      end
    end
  end

  // read port, old contents on read-during-write
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      dout_o <= '0;
    end
    else
    begin
      dout_o <= mem[addr_i];
    end
  end

endmodule
